// File: design/game_cfg.svh
// ####################################################################
// field size and timing constants shared by RTL and testbench
// GAME_TICK_BASE must be a power of two of at least 2**GAME_MAX_LEVEL
// ####################################################################

`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// LED field size, rows run from 0 at the bottom to 7 at the top
`define GAME_ROWS 8
`define GAME_COLS 8

// prescaler period in clock cycles at level 0
// each level halves it, kept short for simulation
`define GAME_TICK_BASE 64

// highest level, the level counter saturates here
`define GAME_MAX_LEVEL 3

// column of the player dot after reset or a new round, bit 4 of row 0
`define GAME_START_COL 4

`endif

// File: design/game_control.sv
// ####################################################################
// game FSM, level counter, collision and win detection, shown frame
// level reads one higher in the cycle that start leaves st_win
// ####################################################################

`timescale 1ns/1ps
`include "game_cfg.svh"

module game_control (
	input  logic                  clock_50,
	input  logic                  reset,
	input  logic                  start,
	input  game_pkg::frame_t      player_frame,
	input  game_pkg::frame_t      obstacle_frame,
	input  game_pkg::pos_t        player_row,
	output logic                  load,
	output logic                  playing,
	output game_pkg::frame_t      frame,
	output game_pkg::game_state_t state,
	output game_pkg::level_t      level
);
	import game_pkg::*;

	game_state_t state_next;
	level_t      level_q;
	logic        collision;
	logic        reached_top;
	logic        level_up;

	// ##################################################################
	// outcome detection
	// ##################################################################

	// any cell lit in both layers is a hit
	assign collision = |(player_frame & obstacle_frame);

	assign reached_top = (player_row == pos_t'(`GAME_ROWS - 1));

	// ##################################################################
	// state machine
	// ##################################################################

	assign load    = start && (state != st_play);
	assign playing = (state == st_play);

	// a hit wins over reaching the top row in the same cycle
	always_comb begin
		state_next = state;
		case (state)
			st_idle, st_win, st_lose: begin
				if (start)
					state_next = st_play;
			end
			st_play: begin
				if (collision)
					state_next = st_lose;
				else if (reached_top)
					state_next = st_win;
			end
			default: state_next = st_idle;
		endcase
	end

	// ##################################################################
	// level counter
	// ##################################################################

	assign level_up = start && (state == st_win) && (level_q != level_t'(`GAME_MAX_LEVEL));

	// the next level is already visible while start is high in st_win,
	// so the obstacle rows load the new level's table at that same edge
	assign level = level_up ? level_q + 1'b1 : level_q;

	always_ff @(posedge clock_50) begin
		if (reset) begin
			state   <= st_idle;
			level_q <= '0;
		end else begin
			state   <= state_next;
			level_q <= level;
		end
	end

	// shown frame is the player layer over the obstacle layer
	assign frame = player_frame | obstacle_frame;

	a_state_legal : assert property (@(posedge clock_50) disable iff (reset)
		state inside {st_idle, st_play, st_win, st_lose});

	a_level_monotonic : assert property (@(posedge clock_50) disable iff (reset)
		level_q >= $past(level_q));

endmodule

// File: design/game_pkg.sv
// ####################################################################
// field, position, level and state types plus the obstacle table
// table rows 0 and 7 are not stored, both stay empty in every level
// ####################################################################

`include "game_cfg.svh"

package game_pkg;

	// one row of lit cells, bit 7 is the leftmost cell
	typedef logic [`GAME_COLS-1:0] row_t;

	// whole field, indexed by row number
	typedef row_t [`GAME_ROWS-1:0] frame_t;

	typedef logic [$clog2(`GAME_ROWS)-1:0] pos_t;

	typedef logic [1:0] level_t;

	typedef enum logic [1:0] {
		st_idle,
		st_play,
		st_win,
		st_lose
	} game_state_t;

	// start pattern of rows 1 to 6 for each level
	// every level keeps the cells of the one before and adds more
	localparam row_t obstacle_table [0:`GAME_MAX_LEVEL][1:`GAME_ROWS-2] = '{
		'{8'b1000_0000, 8'b0000_0001, 8'b1000_0000,
		  8'b0000_0001, 8'b1000_0000, 8'b0000_0001},
		'{8'b1000_1000, 8'b0001_0001, 8'b1000_1000,
		  8'b0001_0001, 8'b1000_1000, 8'b0001_0001},
		'{8'b1100_1000, 8'b0001_0011, 8'b1100_1000,
		  8'b0001_0011, 8'b1100_1000, 8'b0001_0011},
		// densest level, still two gaps per row
		'{8'b1100_1100, 8'b0011_0011, 8'b1100_1100,
		  8'b0011_0011, 8'b1100_1100, 8'b0011_0011}
	};

endpackage

// File: design/game_top.sv
// ####################################################################
// block-dodging game on an 8 by 8 field, clean one-cycle button pulses
// frame is the raw field, no LED driver or display scan is included
// ####################################################################

`timescale 1ns/1ps

module game_top (
	input  logic                  clock_50,
	input  logic                  reset,
	input  logic                  start,
	input  logic                  up,
	input  logic                  down,
	input  logic                  left,
	input  logic                  right,
	output game_pkg::frame_t      frame,
	output game_pkg::game_state_t state,
	output game_pkg::level_t      level
);
	import game_pkg::*;

	frame_t player_frame;
	frame_t obstacle_frame;
	pos_t   player_row;
	logic   load;
	logic   playing;

	// the two layers are built side by side and merged in game_control
	player_field u_player (
		.clock_50     (clock_50),
		.reset        (reset),
		.load         (load),
		.playing      (playing),
		.up           (up),
		.down         (down),
		.left         (left),
		.right        (right),
		.player_frame (player_frame),
		.player_row   (player_row)
	);

	obstacle_field u_obstacle (
		.clock_50       (clock_50),
		.reset          (reset),
		.load           (load),
		.playing        (playing),
		.level          (level),
		.obstacle_frame (obstacle_frame)
	);

	game_control u_control (
		.clock_50       (clock_50),
		.reset          (reset),
		.start          (start),
		.player_frame   (player_frame),
		.obstacle_frame (obstacle_frame),
		.player_row     (player_row),
		.load           (load),
		.playing        (playing),
		.frame          (frame),
		.state          (state),
		.level          (level)
	);

endmodule

// File: design/obstacle_field.sv
// ####################################################################
// obstacle rows 1 to 6, loaded per level and rotated on a speed tick
// the tick period is GAME_TICK_BASE >> level clock cycles
// ####################################################################

`timescale 1ns/1ps
`include "game_cfg.svh"

module obstacle_field (
	input  logic              clock_50,
	input  logic              reset,
	input  logic              load,
	input  logic              playing,
	input  game_pkg::level_t  level,
	output game_pkg::frame_t  obstacle_frame
);
	import game_pkg::*;

	localparam int TICK_W = $clog2(`GAME_TICK_BASE);

	logic [TICK_W-1:0] tick_count;
	logic [TICK_W-1:0] tick_last;
	logic              tick;
	frame_t            rows;

	// ##################################################################
	// speed prescaler
	// ##################################################################

	// last count of the period, shorter at each level
	assign tick_last = TICK_W'((`GAME_TICK_BASE >> level) - 1);

	assign tick = playing && (tick_count == tick_last);

	// the count restarts with every round so the first rotation
	// always lands one full period after load
	always_ff @(posedge clock_50) begin
		if (reset) begin
			tick_count <= '0;
		end else if (load) begin
			tick_count <= '0;
		end else if (playing) begin
			if (tick)
				tick_count <= '0;
			else
				tick_count <= tick_count + 1'b1;
		end
	end

	// ##################################################################
	// obstacle rows
	// ##################################################################

	// rows 0 and 7 are never written after reset
	// odd rows rotate left and even rows rotate right
	always_ff @(posedge clock_50) begin
		if (reset) begin
			rows <= '0;
		end else if (load) begin
			for (int r = 1; r < `GAME_ROWS - 1; r++)
				rows[r] <= obstacle_table[level][r];
		end else if (tick) begin
			for (int r = 1; r < `GAME_ROWS - 1; r++) begin
				if (r % 2 == 1)
					rows[r] <= {rows[r][`GAME_COLS-2:0], rows[r][`GAME_COLS-1]};
				else
					rows[r] <= {rows[r][0], rows[r][`GAME_COLS-1:1]};
			end
		end
	end

	assign obstacle_frame = rows;

	a_edge_rows_empty : assert property (@(posedge clock_50) disable iff (reset)
		(rows[0] == '0) && (rows[`GAME_ROWS-1] == '0));

endmodule

// File: design/player_field.sv
// ####################################################################
// player dot position and its one-hot layer
// moves act only while playing, a move past the border is dropped
// ####################################################################

`timescale 1ns/1ps
`include "game_cfg.svh"

module player_field (
	input  logic             clock_50,
	input  logic             reset,
	input  logic             load,
	input  logic             playing,
	input  logic             up,
	input  logic             down,
	input  logic             left,
	input  logic             right,
	output game_pkg::frame_t player_frame,
	output game_pkg::pos_t   player_row
);
	import game_pkg::*;

	pos_t row_q;
	pos_t col_q;

	// ##################################################################
	// position registers
	// ##################################################################

	// up raises the row, left raises the column since bit 7 is shown leftmost
	// only the highest priority pulse is looked at, up then down, left, right
	always_ff @(posedge clock_50) begin
		if (reset) begin
			row_q <= '0;
			col_q <= pos_t'(`GAME_START_COL);
		end else if (load) begin
			row_q <= '0;
			col_q <= pos_t'(`GAME_START_COL);
		end else if (playing) begin
			if (up) begin
				if (row_q != pos_t'(`GAME_ROWS - 1))
					row_q <= row_q + 1'b1;
			end else if (down) begin
				if (row_q != '0)
					row_q <= row_q - 1'b1;
			end else if (left) begin
				if (col_q != pos_t'(`GAME_COLS - 1))
					col_q <= col_q + 1'b1;
			end else if (right) begin
				if (col_q != '0)
					col_q <= col_q - 1'b1;
			end
		end
	end

	// ##################################################################
	// player layer
	// ##################################################################

	always_comb begin
		player_frame = '0;
		player_frame[row_q][col_q] = 1'b1;
	end

	assign player_row = row_q;

	a_single_dot : assert property (@(posedge clock_50) disable iff (reset)
		$onehot(player_frame));

endmodule

// File: files.f
+incdir+design
design/game_pkg.sv
design/player_field.sv
design/obstacle_field.sv
design/game_control.sv
design/game_top.sv
tests/game_checker.sv
tests/tb_game.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the game testbench with Verilator from the project root
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f files.f \
	--top-module tb_game \
	-o sim_game

./obj_dir/sim_game 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi

echo "simulation passed"

// File: tests/game_checker.sv
// ####################################################################
// reference model of the game rules, compared with the DUT each cycle
// golden expectations are checked when check_req is high
// ####################################################################

`timescale 1ns/1ps
`include "game_cfg.svh"

module game_checker (
	input  logic                  clock_50,
	input  logic                  reset,
	input  logic                  start,
	input  logic                  up,
	input  logic                  down,
	input  logic                  left,
	input  logic                  right,
	input  game_pkg::frame_t      frame,
	input  game_pkg::game_state_t state,
	input  game_pkg::level_t      level,
	input  logic                  check_req,
	input  logic [1:0]            exp_state,
	input  logic [1:0]            exp_level,
	input  logic [2:0]            exp_row,
	input  logic [2:0]            exp_col,
	output int                    model_errors,
	output int                    golden_errors
);
	import game_pkg::*;

	frame_t      m_rows;
	game_state_t m_state;
	level_t      m_level;
	int          m_row;
	int          m_col;
	int          m_count;

	// dir +1 moves each cell one column up (left on the field), -1 moves it down
	function automatic row_t shift_row(row_t r, int dir);
		row_t n;
		for (int c = 0; c < `GAME_COLS; c++)
			n[(c + dir + `GAME_COLS) % `GAME_COLS] = r[c];
		return n;
	endfunction

	// ##################################################################
	// model of the rules, advanced at every rising edge
	// ##################################################################

	always @(posedge clock_50) begin
		int next_level;
		if (reset) begin
			m_rows  <= '0;
			m_state <= st_idle;
			m_level <= '0;
			m_row   <= 0;
			m_col   <= `GAME_START_COL;
			m_count <= 0;
		end else if (m_state == st_play) begin
			if (m_rows[m_row][m_col])
				m_state <= st_lose;
			else if (m_row == `GAME_ROWS - 1)
				m_state <= st_win;
			if (up) begin
				if (m_row < `GAME_ROWS - 1)
					m_row <= m_row + 1;
			end else if (down) begin
				if (m_row > 0)
					m_row <= m_row - 1;
			end else if (left) begin
				if (m_col < `GAME_COLS - 1)
					m_col <= m_col + 1;
			end else if (right) begin
				if (m_col > 0)
					m_col <= m_col - 1;
			end
			if (m_count == (`GAME_TICK_BASE >> m_level) - 1) begin
				m_count <= 0;
				for (int r = 1; r < `GAME_ROWS - 1; r++)
					m_rows[r] <= shift_row(m_rows[r], (r % 2 == 1) ? 1 : -1);
			end else begin
				m_count <= m_count + 1;
			end
		end else if (start) begin
			next_level = int'(m_level);
			if (m_state == st_win && next_level < `GAME_MAX_LEVEL)
				next_level = next_level + 1;
			m_level <= level_t'(next_level);
			m_state <= st_play;
			m_row   <= 0;
			m_col   <= `GAME_START_COL;
			m_count <= 0;
			for (int r = 1; r < `GAME_ROWS - 1; r++)
				m_rows[r] <= obstacle_table[next_level][r];
		end
	end

	// ##################################################################
	// comparisons, on the falling edge where all outputs are settled
	// ##################################################################

	always @(negedge clock_50) begin
		frame_t exp_frame;
		level_t shown_level;
		if (reset) begin
			model_errors  = 0;
			golden_errors = 0;
		end else begin
			exp_frame = m_rows;
			exp_frame[m_row][m_col] = 1'b1;
			// start in st_win already shows the raised level
			shown_level = m_level;
			if (m_state == st_win && start && m_level != level_t'(`GAME_MAX_LEVEL))
				shown_level = m_level + 1'b1;
			if (frame !== exp_frame) begin
				model_errors++;
				$display("[FAIL] t=%0t frame expected %h actual %h", $time, exp_frame, frame);
			end
			if (state !== m_state) begin
				model_errors++;
				$display("[FAIL] t=%0t state expected %0d actual %0d", $time, m_state, state);
			end
			if (level !== shown_level) begin
				model_errors++;
				$display("[FAIL] t=%0t level expected %0d actual %0d", $time, shown_level, level);
			end
			if (check_req) begin
				if (state !== game_state_t'(exp_state)) begin
					golden_errors++;
					$display("[FAIL] t=%0t state expected %0d actual %0d", $time, exp_state, state);
				end
				if (level !== exp_level) begin
					golden_errors++;
					$display("[FAIL] t=%0t level expected %0d actual %0d", $time, exp_level, level);
				end
				if (m_row != int'(exp_row) || m_col != int'(exp_col)) begin
					golden_errors++;
					$display("[FAIL] t=%0t player expected %0d,%0d actual %0d,%0d",
						$time, exp_row, exp_col, m_row, m_col);
				end
				if (frame[exp_row][exp_col] !== 1'b1) begin
					golden_errors++;
					$display("[FAIL] t=%0t frame[%0d][%0d] expected 1 actual %b",
						$time, exp_row, exp_col, frame[exp_row][exp_col]);
				end
			end
		end
	end

endmodule

// File: tests/game_golden.txt
# cmd (s start, u d l r move, w idle) then idle cycles after the pulse
# expected after the wait: state (0 idle 1 play 2 win 3 lose) level row col
u 3 0 0 0 4
l 3 0 0 0 4
s 3 1 0 0 4
d 3 1 0 0 4
l 3 1 0 0 5
l 3 1 0 0 6
l 3 1 0 0 7
l 3 1 0 0 7
r 3 1 0 0 6
r 3 1 0 0 5
r 3 1 0 0 4
u 3 1 0 1 4
u 3 1 0 2 4
u 3 1 0 3 4
u 3 1 0 4 4
u 3 1 0 5 4
u 3 1 0 6 4
u 3 2 0 7 4
u 3 2 0 7 4
s 3 1 1 0 4
r 3 1 1 0 3
u 3 3 1 1 3
u 3 3 1 1 3
s 3 1 1 0 4
l 3 1 1 0 5
w 245 1 1 0 5
u 3 1 1 1 5
u 3 1 1 2 5
u 3 1 1 3 5
u 3 1 1 4 5
u 3 1 1 5 5
u 3 1 1 6 5
u 3 2 1 7 5
s 0 1 2 0 4
l 0 1 2 0 5
u 0 1 2 1 5
u 0 1 2 2 5
u 0 1 2 3 5
u 0 1 2 4 5
u 0 1 2 5 5
u 0 1 2 6 5
u 3 2 2 7 5
s 3 1 3 0 4
l 2 1 3 0 5
u 0 1 3 1 5
u 0 1 3 2 5
u 0 1 3 3 5
u 0 1 3 4 5
r 6 1 3 4 4
u 0 1 3 5 4
u 0 1 3 6 4
u 3 2 3 7 4
s 3 1 3 0 4

// File: tests/tb_game.sv
// ####################################################################
// testbench top, replays tests/game_golden.txt against game_top
// run it from the project root so the golden file path resolves
// ####################################################################

`timescale 1ns/1ps
`include "game_cfg.svh"

module tb_game;
	import game_pkg::*;

	logic        clock_50;
	logic        reset;
	logic        start;
	logic        up;
	logic        down;
	logic        left;
	logic        right;
	frame_t      frame;
	game_state_t state;
	level_t      level;
	logic        check_req;
	logic [1:0]  exp_state;
	logic [1:0]  exp_level;
	logic [2:0]  exp_row;
	logic [2:0]  exp_col;
	int          model_errors;
	int          golden_errors;
	int          file_errors;
	int          total_wait;
	logic        steps_loaded;

	// one entry per golden line
	byte cmd_q[$];
	int  wait_q[$];
	int  state_q[$];
	int  level_q[$];
	int  row_q[$];
	int  col_q[$];

	game_top u_dut (
		.clock_50 (clock_50),
		.reset    (reset),
		.start    (start),
		.up       (up),
		.down     (down),
		.left     (left),
		.right    (right),
		.frame    (frame),
		.state    (state),
		.level    (level)
	);

	game_checker u_checker (
		.clock_50      (clock_50),
		.reset         (reset),
		.start         (start),
		.up            (up),
		.down          (down),
		.left          (left),
		.right         (right),
		.frame         (frame),
		.state         (state),
		.level         (level),
		.check_req     (check_req),
		.exp_state     (exp_state),
		.exp_level     (exp_level),
		.exp_row       (exp_row),
		.exp_col       (exp_col),
		.model_errors  (model_errors),
		.golden_errors (golden_errors)
	);

	initial begin
		clock_50 = 1'b0;
		forever #10 clock_50 = ~clock_50;
	end

	task automatic read_golden();
		int    fd;
		int    n;
		string line;
		byte   c;
		int    w, s, l, r, k;
		fd = $fopen("tests/game_golden.txt", "r");
		if (fd == 0) begin
			file_errors++;
			$display("could not open tests/game_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n == 0 || line.len() == 0 || line[0] == "#")
					continue;
				n = $sscanf(line, "%c %d %d %d %d %d", c, w, s, l, r, k);
				if (n == 6) begin
					cmd_q.push_back(c);
					wait_q.push_back(w);
					state_q.push_back(s);
					level_q.push_back(l);
					row_q.push_back(r);
					col_q.push_back(k);
					total_wait += w;
				end
			end
			$fclose(fd);
		end
		if (cmd_q.size() == 0) begin
			file_errors++;
			$display("the golden file holds no steps");
		end
	endtask

	// one pulse, the idle cycles, then the expectations go to the checker
	task automatic run_step(int i);
		@(posedge clock_50);
		check_req <= 1'b0;
		case (cmd_q[i])
			"s": start <= 1'b1;
			"u": up <= 1'b1;
			"d": down <= 1'b1;
			"l": left <= 1'b1;
			"r": right <= 1'b1;
			"w": ;
			default: begin
				file_errors++;
				$display("unknown command %c in the golden file", cmd_q[i]);
			end
		endcase
		@(posedge clock_50);
		start <= 1'b0;
		up    <= 1'b0;
		down  <= 1'b0;
		left  <= 1'b0;
		right <= 1'b0;
		repeat (wait_q[i]) @(posedge clock_50);
		exp_state <= state_q[i][1:0];
		exp_level <= level_q[i][1:0];
		exp_row   <= row_q[i][2:0];
		exp_col   <= col_q[i][2:0];
		check_req <= 1'b1;
	endtask

	initial begin
		reset        = 1'b1;
		start        = 1'b0;
		up           = 1'b0;
		down         = 1'b0;
		left         = 1'b0;
		right        = 1'b0;
		check_req    = 1'b0;
		exp_state    = '0;
		exp_level    = '0;
		exp_row      = '0;
		exp_col      = '0;
		file_errors  = 0;
		total_wait   = 0;
		steps_loaded = 1'b0;
		read_golden();
		steps_loaded = 1'b1;
		repeat (16) @(posedge clock_50);
		reset <= 1'b0;
		foreach (cmd_q[i])
			run_step(i);
		@(posedge clock_50);
		check_req <= 1'b0;
		repeat (4) @(posedge clock_50);
		$display("errors: model %0d golden %0d file %0d", model_errors, golden_errors,
			file_errors);
		if (model_errors + golden_errors + file_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// limit grows with the idle cycles listed in the golden file
	initial begin
		wait (steps_loaded);
		repeat (2 * total_wait + 1000) @(posedge clock_50);
		$display("timeout, the golden steps did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
